/* verilog/wbp_pkg.sv */
// Packet bridge definitions
package wbp_pkg;

   // Stream word layout, bit 18 is a spare flag
   localparam int stream_width = 19;
   localparam int data_width   = 16;
   localparam int sof_bit      = 16;
   localparam int eof_bit      = 17;
   localparam int trig_width   = 6;

   // First word of a command packet
   typedef struct packed {
      logic                  rd;
      logic                  wr;
      logic [trig_width-1:0] trig_mask;
      logic [7:0]            seqno;
   } cmd_word_t;

   // One 16-bit word, seen as plain data or as a command word
   typedef union packed {
      logic [data_width-1:0] raw;
      cmd_word_t             cmd;
   } ctrl_word_u;

   // Takes the place of rd, wr and trig_mask in the response command word
   localparam logic [7:0] resp_marker = 8'hAA;

   // Register bank geometry
   localparam int reg_words     = 64;
   localparam int reg_addr_bits = 6;

   localparam int fifo_depth    = 16;
   localparam int fifo_ptr_bits = 4;

   // Packet engine states
   localparam logic [3:0] st_idle      = 4'd0;
   localparam logic [3:0] st_len       = 4'd1;
   localparam logic [3:0] st_addr_lsw  = 4'd2;
   localparam logic [3:0] st_addr_msw  = 4'd3;
   localparam logic [3:0] st_write     = 4'd4;
   localparam logic [3:0] st_dump      = 4'd5;
   localparam logic [3:0] st_trig_wait = 4'd6;
   localparam logic [3:0] st_rcmd      = 4'd7;
   localparam logic [3:0] st_rlen      = 4'd8;
   localparam logic [3:0] st_raddr_lsw = 4'd9;
   localparam logic [3:0] st_raddr_msw = 4'd10;
   localparam logic [3:0] st_read      = 4'd11;

endpackage

/* verilog/wbp_stream_if.sv */
// Packet stream bundle
`timescale 1ns/10ps

interface wbp_stream_if
   import wbp_pkg::*;
();

   logic [stream_width-1:0] data;
   logic                    src_rdy;
   logic                    dst_rdy;

   modport source (
      output data,
      output src_rdy,
      input  dst_rdy
   );

   modport sink (
      input  data,
      input  src_rdy,
      output dst_rdy
   );

endinterface

/* verilog/short_fifo.sv */
// Short stream FIFO
`timescale 1ns/10ps

module short_fifo
   import wbp_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         clear_i,
   wbp_stream_if.sink   in_s,
   wbp_stream_if.source out_s
);

   logic [stream_width-1:0]  mem [fifo_depth];
   logic [fifo_ptr_bits-1:0] wr_ptr;
   logic [fifo_ptr_bits-1:0] rd_ptr;
   logic [fifo_ptr_bits:0]   count;
   logic                     push;
   logic                     pop;

   assign push = in_s.src_rdy & in_s.dst_rdy;
   assign pop  = out_s.src_rdy & out_s.dst_rdy;

   // Full only blocks the writer, empty only hides the head
   assign in_s.dst_rdy  = (count != (fifo_ptr_bits + 1)'(fifo_depth));
   assign out_s.src_rdy = (count != '0);

   // First word falls through to the output
   assign out_s.data = mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + {{fifo_ptr_bits{1'b0}}, push} - {{fifo_ptr_bits{1'b0}}, pop};
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_s.data;
   end

   // No overflow or underflow ever shows up in the fill level
   a_count_range: assert property (@(posedge clk) disable iff (!rst_n_i)
      count <= fifo_depth);

   // Pointer distance tracks the fill level
   a_ptr_count: assert property (@(posedge clk) disable iff (!rst_n_i)
      (wr_ptr - rd_ptr) == count[fifo_ptr_bits-1:0]);

endmodule

/* verilog/wb_packet_engine.sv */
// Command packet engine
`timescale 1ns/10ps

module wb_packet_engine
   import wbp_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  clear_i,
   wbp_stream_if.sink            ctrl_s,
   wbp_stream_if.source          resp_s,
   input  logic [trig_width-1:0] triggers_i,
   output logic [data_width-1:0] wb_adr_o,
   output logic [data_width-1:0] wb_dat_mosi_o,
   input  logic [data_width-1:0] wb_dat_miso_i,
   output logic                  wb_we_o,
   output logic                  wb_stb_o,
   output logic                  wb_cyc_o,
   input  logic                  wb_ack_i
);

   logic [3:0]            state;
   logic [3:0]            done_state;
   logic                  rd;
   logic                  wr;
   logic [trig_width-1:0] trig_mask;
   logic [7:0]            seqno;
   logic [data_width-1:0] base_addr;
   logic [data_width-1:0] length;
   logic [data_width-1:0] count;
   ctrl_word_u            ctrl_word;
   ctrl_word_u            resp_word;
   logic                  ctrl_sof;
   logic                  ctrl_eof;
   logic                  last_word;
   logic                  trig_ok;
   logic                  bus_done;
   logic                  resp_sof;
   logic                  resp_eof;

   always_comb
   begin
      ctrl_word.raw = ctrl_s.data[data_width-1:0];
   end

   assign ctrl_sof  = ctrl_s.data[sof_bit];
   assign ctrl_eof  = ctrl_s.data[eof_bit];
   assign last_word = (count == data_width'(1));
   assign bus_done  = wb_stb_o & wb_ack_i;

   // Every trigger picked by the mask must be high
   assign trig_ok = &(triggers_i | ~trig_mask);

   // Where a packet goes once its eof is consumed
   assign done_state = rd ? st_trig_wait : st_idle;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state     <= st_idle;
         rd        <= 1'b0;
         wr        <= 1'b0;
         trig_mask <= '0;
         count     <= '0;
         wb_adr_o  <= '0;
      end
      else if (clear_i)
      begin
         state <= st_idle;
      end
      else
      begin
         case (state)
            st_idle:
               // Stray words without sof just drain here
               if (ctrl_s.src_rdy && ctrl_sof)
               begin
                  rd        <= ctrl_word.cmd.rd;
                  wr        <= ctrl_word.cmd.wr;
                  trig_mask <= ctrl_word.cmd.trig_mask;
                  state     <= st_len;
               end
            st_len:
               if (ctrl_s.src_rdy)
               begin
                  count <= ctrl_word.raw;
                  state <= st_addr_lsw;
               end
            st_addr_lsw:
               if (ctrl_s.src_rdy)
               begin
                  wb_adr_o <= ctrl_word.raw;
                  state    <= st_addr_msw;
               end
            st_addr_msw:
               // High address word is dropped
               if (ctrl_s.src_rdy)
               begin
                  if (wr)
                     state <= st_write;
                  else if (ctrl_eof)
                     state <= done_state;
                  else
                     state <= st_dump;
               end
            st_write:
               if (bus_done)
               begin
                  if (!last_word)
                  begin
                     wb_adr_o <= wb_adr_o + data_width'(2);
                     count    <= count - data_width'(1);
                  end
                  else if (ctrl_eof)
                     state <= done_state;
                  else
                     state <= st_dump;
               end
            st_dump:
               if (ctrl_s.src_rdy && ctrl_eof)
                  state <= done_state;
            st_trig_wait:
            begin
               // Rewind to the packet's base for the read burst
               wb_adr_o <= base_addr;
               count    <= length;
               if (trig_ok)
                  state <= st_rcmd;
            end
            st_rcmd:
               if (resp_s.dst_rdy)
                  state <= st_rlen;
            st_rlen:
               if (resp_s.dst_rdy)
                  state <= st_raddr_lsw;
            st_raddr_lsw:
               if (resp_s.dst_rdy)
                  state <= st_raddr_msw;
            st_raddr_msw:
               if (resp_s.dst_rdy)
                  state <= st_read;
            st_read:
               if (bus_done)
               begin
                  if (last_word)
                     state <= st_idle;
                  else
                  begin
                     wb_adr_o <= wb_adr_o + data_width'(2);
                     count    <= count - data_width'(1);
                  end
               end
            default:
               state <= st_idle;
         endcase
      end
   end

   // Header fields echoed in the response
   always_ff @(posedge clk)
   begin
      if (state == st_idle && ctrl_s.src_rdy && ctrl_sof)
         seqno <= ctrl_word.cmd.seqno;
      if (state == st_len && ctrl_s.src_rdy)
         length <= ctrl_word.raw;
      if (state == st_addr_lsw && ctrl_s.src_rdy)
         base_addr <= ctrl_word.raw;
   end

   // Response word comes from the header fields or the bus
   always_comb
   begin
      resp_word.raw = wb_dat_miso_i;
      resp_sof      = 1'b0;
      resp_eof      = 1'b0;
      case (state)
         st_rcmd:
         begin
            {resp_word.cmd.rd, resp_word.cmd.wr, resp_word.cmd.trig_mask} = resp_marker;
            resp_word.cmd.seqno = seqno;
            resp_sof            = 1'b1;
         end
         st_rlen:
            resp_word.raw = length;
         st_raddr_lsw:
            resp_word.raw = base_addr;
         st_raddr_msw:
            resp_word.raw = '0;
         default:
            resp_eof = last_word;
      endcase
   end

   assign resp_s.data = {1'b0, resp_eof, resp_sof, resp_word.raw};

   assign resp_s.src_rdy = (state == st_rcmd) || (state == st_rlen)
                        || (state == st_raddr_lsw) || (state == st_raddr_msw)
                        || (state == st_read && bus_done);

   assign ctrl_s.dst_rdy = (state == st_idle) || (state == st_len)
                        || (state == st_addr_lsw) || (state == st_addr_msw)
                        || (state == st_dump) || (state == st_write && bus_done);

   // Strobe waits for write data or for room in the response FIFO
   assign wb_stb_o      = (state == st_write && ctrl_s.src_rdy)
                       || (state == st_read && resp_s.dst_rdy);
   assign wb_cyc_o      = wb_stb_o;
   assign wb_we_o       = (state == st_write);
   assign wb_dat_mosi_o = ctrl_word.raw;

   // Strobe only inside a burst that still has words to move
   a_stb_in_burst: assert property (@(posedge clk) disable iff (!rst_n_i)
      $rose(wb_stb_o) |-> ((state == st_write) || (state == st_read)) && count != '0);

   // Address and data stay put until the bank answers
   a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n_i || clear_i)
      wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_mosi_o));

   a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
      $changed(state) && (state == st_write || state == st_read) |-> length != '0);

endmodule

/* verilog/wb_reg_bank.sv */
// Wishbone register bank
`timescale 1ns/10ps

module wb_reg_bank
   import wbp_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic [data_width-1:0] wb_adr_i,
   input  logic [data_width-1:0] wb_dat_i,
   output logic [data_width-1:0] wb_dat_o,
   input  logic                  wb_we_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   output logic                  wb_ack_o
);

   logic [data_width-1:0]    regs [reg_words];
   logic [reg_addr_bits-1:0] idx;
   logic                     access;

   // Word index, bit 0 selects a byte and is unused
   assign idx = wb_adr_i[reg_addr_bits:1];

   // Strobe seen during the ack cycle belongs to the access just served
   assign access = wb_stb_i & wb_cyc_i & ~wb_ack_o;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wb_ack_o <= 1'b0;
         for (int i = 0; i < reg_words; i++)
            regs[i] <= '0;
      end
      else
      begin
         wb_ack_o <= access;
         if (access && wb_we_i)
            regs[idx] <= wb_dat_i;
      end
   end

   // Read data lines up with the ack
   always_ff @(posedge clk)
   begin
      if (access)
         wb_dat_o <= regs[idx];
   end

   a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
      wb_ack_o |-> $past(wb_stb_i && wb_cyc_i));

endmodule

/* verilog/wb_packet_bridge.sv */
// Packet to Wishbone bridge
`timescale 1ns/10ps

module wb_packet_bridge
   import wbp_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    clear_i,
   input  logic [stream_width-1:0] data_i,
   input  logic                    src_rdy_i,
   output logic                    dst_rdy_o,
   output logic [stream_width-1:0] data_o,
   output logic                    src_rdy_o,
   input  logic                    dst_rdy_i,
   input  logic [trig_width-1:0]   triggers_i
);

   wbp_stream_if host_in_s ();
   wbp_stream_if ctrl_s ();
   wbp_stream_if resp_s ();
   wbp_stream_if host_out_s ();

   // Bus from engine to register bank
   logic [data_width-1:0] wb_adr;
   logic [data_width-1:0] wb_dat_mosi;
   logic [data_width-1:0] wb_dat_miso;
   logic                  wb_we;
   logic                  wb_stb;
   logic                  wb_cyc;
   logic                  wb_ack;

   assign host_in_s.data     = data_i;
   assign host_in_s.src_rdy  = src_rdy_i;
   assign dst_rdy_o          = host_in_s.dst_rdy;
   assign data_o             = host_out_s.data;
   assign src_rdy_o          = host_out_s.src_rdy;
   assign host_out_s.dst_rdy = dst_rdy_i;

   short_fifo ctrl_fifo (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .clear_i (clear_i),
      .in_s    (host_in_s),
      .out_s   (ctrl_s)
   );

   short_fifo resp_fifo (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .clear_i (clear_i),
      .in_s    (resp_s),
      .out_s   (host_out_s)
   );

   wb_packet_engine engine (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .clear_i       (clear_i),
      .ctrl_s        (ctrl_s),
      .resp_s        (resp_s),
      .triggers_i    (triggers_i),
      .wb_adr_o      (wb_adr),
      .wb_dat_mosi_o (wb_dat_mosi),
      .wb_dat_miso_i (wb_dat_miso),
      .wb_we_o       (wb_we),
      .wb_stb_o      (wb_stb),
      .wb_cyc_o      (wb_cyc),
      .wb_ack_i      (wb_ack)
   );

   wb_reg_bank regs (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_mosi),
      .wb_dat_o (wb_dat_miso),
      .wb_we_i  (wb_we),
      .wb_stb_i (wb_stb),
      .wb_cyc_i (wb_cyc),
      .wb_ack_o (wb_ack)
   );

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o   = 1'b0;
      rst_n_o = 1'b0;
      // Reset covers two rising edges and lifts on a falling edge
      repeat (2) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

   // 8 ns period
   always #4 clk_o = ~clk_o;

endmodule

/* test/wb_packet_bridge_tb.sv */
// Packet bridge testbench
`timescale 1ns/10ps

module wb_packet_bridge_tb
   import wbp_pkg::*;
();

   logic                    clk;
   logic                    rst_n;
   logic                    clear_i;
   logic [stream_width-1:0] data_i;
   logic                    src_rdy_i;
   logic                    dst_rdy_o;
   logic [stream_width-1:0] data_o;
   logic                    src_rdy_o;
   logic                    dst_rdy_i;
   logic [trig_width-1:0]   triggers_i;

   logic [data_width-1:0]   ref_mem [reg_words];
   logic [data_width-1:0]   wdata [32];
   logic [stream_width-1:0] exp_q [$];
   logic [stream_width-1:0] exp_head;
   int                      exp_count;
   logic                    trig_hold;

   tb_clock_gen clock_gen_i (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   wb_packet_bridge wb_packet_bridge_i (
      .clk        (clk),
      .rst_n_i    (rst_n),
      .clear_i    (clear_i),
      .data_i     (data_i),
      .src_rdy_i  (src_rdy_i),
      .dst_rdy_o  (dst_rdy_o),
      .data_o     (data_o),
      .src_rdy_o  (src_rdy_o),
      .dst_rdy_i  (dst_rdy_i),
      .triggers_i (triggers_i)
   );

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1);
   endtask

   function automatic logic [stream_width-1:0] pack_word(input logic sof, input logic eof,
                                                         input logic [data_width-1:0] d);
      logic [stream_width-1:0] w;
      w                   = '0;
      w[sof_bit]          = sof;
      w[eof_bit]          = eof;
      w[data_width-1:0]   = d;
      return w;
   endfunction

   // Register index from a byte address
   function automatic logic [reg_addr_bits-1:0] ref_index(input logic [data_width-1:0] a);
      return reg_addr_bits'((a >> 1) % reg_words);
   endfunction

   function automatic void refresh_head();
      exp_count = exp_q.size();
      exp_head  = (exp_count != 0) ? exp_q[0] : '0;
   endfunction

   // Response packet for a read burst, taken from the reference memory
   task automatic expect_read(input logic [7:0] seqno, input int len,
                              input logic [data_width-1:0] addr);
      logic [data_width-1:0] a;
      exp_q.push_back(pack_word(1'b1, 1'b0, {resp_marker, seqno}));
      exp_q.push_back(pack_word(1'b0, 1'b0, data_width'(len)));
      exp_q.push_back(pack_word(1'b0, 1'b0, addr));
      exp_q.push_back(pack_word(1'b0, 1'b0, '0));
      for (int i = 0; i < len; i++)
      begin
         a = addr + data_width'(2 * i);
         exp_q.push_back(pack_word(1'b0, i == len - 1, ref_mem[ref_index(a)]));
      end
      refresh_head();
   endtask

   // Called on a falling edge, returns on a falling edge
   task automatic send_word(input logic [stream_width-1:0] word);
      int waited;
      waited    = 0;
      data_i    = word;
      src_rdy_i = 1'b1;
      // dst_rdy_o only moves on a rising edge, so this value holds for the next one
      while (!dst_rdy_o)
      begin
         @(negedge clk);
         waited++;
         if (waited > 1000)
            stop_with_failure("Timed out waiting for the command stream to accept a word");
      end
      @(negedge clk);
      src_rdy_i = 1'b0;
   endtask

   task automatic send_command(input logic rd, input logic wr, input logic [trig_width-1:0] mask,
                               input logic [7:0] seqno, input int len,
                               input logic [data_width-1:0] addr, input int pad);
      ctrl_word_u cw;
      if (wr)
         for (int i = 0; i < len; i++)
            ref_mem[ref_index(addr + data_width'(2 * i))] = wdata[i];
      if (rd)
         expect_read(seqno, len, addr);
      cw.raw           = '0;
      cw.cmd.rd        = rd;
      cw.cmd.wr        = wr;
      cw.cmd.trig_mask = mask;
      cw.cmd.seqno     = seqno;
      send_word(pack_word(1'b1, 1'b0, cw.raw));
      send_word(pack_word(1'b0, 1'b0, data_width'(len)));
      send_word(pack_word(1'b0, 1'b0, addr));
      // High address word carries junk
      send_word(pack_word(1'b0, !wr && pad == 0, data_width'($urandom)));
      if (wr)
         for (int i = 0; i < len; i++)
            send_word(pack_word(1'b0, i == len - 1 && pad == 0, wdata[i]));
      for (int i = 0; i < pad; i++)
         send_word(pack_word(1'b0, i == pad - 1, data_width'($urandom)));
   endtask

   task automatic drain_responses(input logic random_bp, input int limit);
      int waited;
      waited = 0;
      while (exp_count != 0)
      begin
         dst_rdy_i = random_bp ? (($urandom % 3) == 0) : 1'b1;
         @(negedge clk);
         waited++;
         if (waited > limit)
            stop_with_failure("Timed out waiting for the response packet");
      end
      dst_rdy_i = 1'b1;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
         @(negedge clk);
   endtask

   task automatic fill_wdata(input int len);
      for (int i = 0; i < len; i++)
         wdata[i] = data_width'($urandom);
   endtask

   // Scoreboard side of the response stream
   always @(posedge clk)
   begin
      if (rst_n && src_rdy_o && dst_rdy_i && exp_q.size() != 0)
      begin
         void'(exp_q.pop_front());
         refresh_head();
      end
   end

   a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
      src_rdy_o && dst_rdy_i && exp_count != 0 |-> data_o == exp_head)
   else
      stop_with_failure($sformatf("FAILED %0t data_o expected %h got %h", $time,
                                  $sampled(exp_head), $sampled(data_o)));

   a_resp_known: assert property (@(posedge clk) disable iff (!rst_n)
      src_rdy_o && dst_rdy_i |-> exp_count != 0)
   else
      stop_with_failure($sformatf("Response word %h came out with none expected at %0t",
                                  $sampled(data_o), $time));

   a_trig_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      trig_hold |-> !src_rdy_o)
   else
      stop_with_failure("Response started while the selected triggers were not all high");

   initial
   begin
      int unsigned           rnd;
      int                    len;
      int                    waited;
      logic [data_width-1:0] addr;
      logic [trig_width-1:0] mask;
      rnd        = $urandom(32'h8206);
      clear_i    = 1'b0;
      data_i     = '0;
      src_rdy_i  = 1'b0;
      dst_rdy_i  = 1'b1;
      triggers_i = '0;
      trig_hold  = 1'b0;
      for (int i = 0; i < reg_words; i++)
         ref_mem[i] = '0;
      refresh_head();

      waited = 0;
      while (rst_n !== 1'b1)
      begin
         @(negedge clk);
         waited++;
         if (waited > 20)
            stop_with_failure("Reset never released");
      end
      @(negedge clk);

      // Idle after reset
      assert (src_rdy_o == 1'b0)
      else
         stop_with_failure($sformatf("FAILED %0t src_rdy_o expected 0 got %b", $time, src_rdy_o));
      assert (dst_rdy_o == 1'b1)
      else
         stop_with_failure($sformatf("FAILED %0t dst_rdy_o expected 1 got %b", $time, dst_rdy_o));

      // Write then read back
      len  = 1 + (rnd % 8);
      addr = data_width'($urandom) & 16'hFFFE;
      fill_wdata(len);
      send_command(1'b1, 1'b1, '0, 8'h11, len, addr, 2);
      drain_responses(1'b0, 500);

      // Stray words ahead of a packet with longer padding
      for (int i = 0; i < 3; i++)
         send_word(pack_word(1'b0, 1'b0, data_width'($urandom)));
      len  = 1 + ($urandom % 8);
      addr = data_width'($urandom) & 16'hFFFE;
      fill_wdata(len);
      send_command(1'b1, 1'b1, '0, 8'h22, len, addr, 4);
      drain_responses(1'b0, 500);

      // Triggered read, first none then all but one selected trigger high
      mask = trig_width'(1 + ($urandom % 63));
      send_command(1'b1, 1'b0, mask, 8'h33, len, addr, 1);
      trig_hold = 1'b1;
      idle_cycles(40);
      triggers_i = ~mask | (mask & (mask - 1'b1));
      idle_cycles(40);
      trig_hold  = 1'b0;
      triggers_i = '1;
      drain_responses(1'b0, 500);
      triggers_i = '0;

      // Long burst behind a stalled then jittery response stream
      len  = 20;
      addr = data_width'($urandom) & 16'hFFFE;
      fill_wdata(len);
      dst_rdy_i = 1'b0;
      send_command(1'b1, 1'b1, '0, 8'h44, len, addr, 1);
      drain_responses(1'b1, 4000);

      // Write only, then read the same words back
      len  = 1 + ($urandom % 8);
      addr = data_width'($urandom) & 16'hFFFE;
      fill_wdata(len);
      send_command(1'b0, 1'b1, '0, 8'h55, len, addr, 0);
      idle_cycles(30);
      send_command(1'b1, 1'b0, '0, 8'h66, len, addr, 2);
      drain_responses(1'b0, 500);
      idle_cycles(20);

      if (exp_count != 0)
         stop_with_failure("Expected response words still outstanding at the end");
      else
      begin
         $display("test passed");
         $finish;
      end
   end

endmodule

/* verilog.f */
verilog/wbp_pkg.sv
verilog/wbp_stream_if.sv
verilog/short_fifo.sv
verilog/wb_packet_engine.sv
verilog/wb_reg_bank.sv
verilog/wb_packet_bridge.sv
test/tb_clock_gen.sv
test/wb_packet_bridge_tb.sv

/* Bender.yml */
package:
  name: wb_packet_bridge

sources:
  # RTL in compile order
  - files:
      - verilog/wbp_pkg.sv
      - verilog/wbp_stream_if.sv
      - verilog/short_fifo.sv
      - verilog/wb_packet_engine.sv
      - verilog/wb_reg_bank.sv
      - verilog/wb_packet_bridge.sv

  # Testbench
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/wb_packet_bridge_tb.sv
